/* project.f */
rtl/mm_bus_pkg.sv
rtl/mm_vp_pkg.sv
rtl/mm_req_decode.sv
rtl/mm_dp_ram.sv
rtl/mm_vp_regs.sv
rtl/mm_ram.sv
verification/mm_ram_tb.sv

/* verification/mm_ram_tb.sv */
/*
 * testbench for the memory-mapped RAM: reference memory and peripheral
 * model, stimulus tasks for both ports and a response-comparing process
 */
`timescale 1ns/10ps
`default_nettype none

module mm_ram_tb;

    // --------------------------------------------------
    // test sizes and run limit
    // --------------------------------------------------
    localparam int unsigned RESET_CYCLES = 8;
    localparam int unsigned FILL_WORDS   = 256;
    localparam int unsigned N_RAND       = 200;
    localparam int unsigned N_PIPE       = 64;
    // rough cycle count of reset plus the five tests
    localparam int unsigned TEST_CYCLES  = RESET_CYCLES + 20 + (FILL_WORDS + 2 * N_RAND + 10)
                                           + (N_PIPE + 10) + 30 + 40;
    localparam int unsigned MAX_CYCLES   = 2 * TEST_CYCLES;

    // one expected response, with the cycle of its request
    typedef struct packed {
        mm_bus_pkg::addr_t addr;
        mm_bus_pkg::word_t data;
        logic [31:0]       cycle;
    } resp_t;

    logic              clk_i;
    logic              rst_i;
    logic              instr_req_i;
    mm_bus_pkg::addr_t instr_addr_i;
    logic              instr_gnt_o;
    logic              instr_rvalid_o;
    mm_bus_pkg::word_t instr_rdata_o;
    logic              data_req_i;
    mm_bus_pkg::addr_t data_addr_i;
    logic              data_we_i;
    mm_bus_pkg::be_t   data_be_i;
    mm_bus_pkg::word_t data_wdata_i;
    logic              data_gnt_o;
    logic              data_rvalid_o;
    mm_bus_pkg::word_t data_rdata_o;
    logic              stdout_valid_o;
    logic [7:0]        stdout_char_o;
    logic              tests_passed_o;
    logic              tests_failed_o;
    logic              exit_valid_o;
    mm_bus_pkg::word_t exit_value_o;

    // reference model state
    mm_bus_pkg::word_t ref_mem [mm_bus_pkg::RAM_WORDS];
    logic              exp_passed;
    logic              exp_failed;
    logic              exp_exit_valid;
    // outstanding responses per port, and expected stdout characters
    resp_t             data_q[$];
    resp_t             instr_q[$];
    resp_t             char_q[$];

    int unsigned       cycle_cnt = 0;
    int unsigned       err_cnt = 0;
    int unsigned       check_cnt = 0;
    integer            seed;

    mm_ram uut (
        .clk_i(clk_i), .rst_i(rst_i),
        .instr_req_i(instr_req_i), .instr_addr_i(instr_addr_i), .instr_gnt_o(instr_gnt_o),
        .instr_rvalid_o(instr_rvalid_o), .instr_rdata_o(instr_rdata_o),
        .data_req_i(data_req_i), .data_addr_i(data_addr_i), .data_we_i(data_we_i),
        .data_be_i(data_be_i), .data_wdata_i(data_wdata_i), .data_gnt_o(data_gnt_o),
        .data_rvalid_o(data_rvalid_o), .data_rdata_o(data_rdata_o),
        .stdout_valid_o(stdout_valid_o), .stdout_char_o(stdout_char_o),
        .tests_passed_o(tests_passed_o), .tests_failed_o(tests_failed_o),
        .exit_valid_o(exit_valid_o), .exit_value_o(exit_value_o)
    );

    initial begin
        clk_i = 1'b0;
        forever begin
            #10 clk_i = ~clk_i;
        end
    end

    // cycle counter, also the run limit
    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // --------------------------------------------------
    // reference model
    // --------------------------------------------------
    // RAM below 0x1000_0000, 4 KiB wrapping, everything else reads zero
    function automatic mm_bus_pkg::word_t ref_read(input mm_bus_pkg::addr_t addr);
        mm_bus_pkg::word_t result;
        result = '0;
        if (addr < 32'h1000_0000) begin
            result = ref_mem[addr[11:2]];
        end
        return result;
    endfunction

    // status read: bit 0 passed, bit 1 failed, bit 2 exit valid
    function automatic mm_bus_pkg::word_t expected_read(input mm_bus_pkg::addr_t addr);
        if (addr == mm_vp_pkg::VP_STATUS_ADDR) begin
            return {29'b0, exp_exit_valid, exp_failed, exp_passed};
        end
        return ref_read(addr);
    endfunction

    // pattern over the full address, so aliasing shows up
    function automatic mm_bus_pkg::word_t fill_word(input mm_bus_pkg::addr_t addr);
        return (addr * 32'h9E37_79B9) ^ 32'hC3A5_0F1E;
    endfunction

    task automatic model_write(input mm_bus_pkg::addr_t addr, input mm_bus_pkg::be_t be,
                               input mm_bus_pkg::word_t wdata);
        if (addr < 32'h1000_0000) begin
            for (int b = 0; b < 4; b++) begin
                if (be[b]) begin
                    ref_mem[addr[11:2]][8*b +: 8] = wdata[8*b +: 8];
                end
            end
        end else if (addr == mm_vp_pkg::VP_STDOUT_ADDR) begin
            char_q.push_back('{addr: addr, data: {24'b0, wdata[7:0]}, cycle: cycle_cnt});
        end else if (addr == mm_vp_pkg::VP_STATUS_ADDR) begin
            // first verdict sticks, other values leave the status alone
            if (wdata == mm_vp_pkg::TEST_PASS_MAGIC && !exp_failed) begin
                exp_passed = 1'b1;
            end
            if (wdata == mm_vp_pkg::TEST_FAIL_MAGIC && !exp_passed) begin
                exp_failed = 1'b1;
            end
        end else if (addr == mm_vp_pkg::VP_EXIT_ADDR) begin
            exp_exit_valid = 1'b1;
        end
    endtask

    // --------------------------------------------------
    // stimulus, all called at a falling edge
    // --------------------------------------------------
    task automatic put_data(input mm_bus_pkg::addr_t addr, input logic we,
                            input mm_bus_pkg::be_t be, input mm_bus_pkg::word_t wdata);
        mm_bus_pkg::word_t exp;
        exp = we ? '0 : expected_read(addr);
        if (we) begin
            model_write(addr, be, wdata);
        end
        data_q.push_back('{addr: addr, data: exp, cycle: cycle_cnt});
        data_req_i   = 1'b1;
        data_addr_i  = addr;
        data_we_i    = we;
        data_be_i    = be;
        data_wdata_i = wdata;
    endtask

    task automatic put_fetch(input mm_bus_pkg::addr_t addr);
        instr_q.push_back('{addr: addr, data: ref_read(addr), cycle: cycle_cnt});
        instr_req_i  = 1'b1;
        instr_addr_i = addr;
    endtask

    // grants are combinational, checked shortly after the inputs settle
    task automatic next_cycle;
        #1;
        check_cnt++;
        if (data_req_i && !data_gnt_o) begin
            $display("error at %0t: data request to %h was not granted", $time, data_addr_i);
            err_cnt++;
        end
        if (instr_req_i && !instr_gnt_o) begin
            $display("error at %0t: fetch from %h was not granted", $time, instr_addr_i);
            err_cnt++;
        end
        @(negedge clk_i);
        data_req_i  = 1'b0;
        data_we_i   = 1'b0;
        instr_req_i = 1'b0;
    endtask

    // wait until every expected response and character has come back
    task automatic drain;
        while (data_q.size() != 0 || instr_q.size() != 0 || char_q.size() != 0) begin
            @(negedge clk_i);
        end
        @(negedge clk_i);
    endtask

    task automatic check_out(input string what, input mm_bus_pkg::word_t got,
                             input mm_bus_pkg::word_t exp);
        check_cnt++;
        if (got !== exp) begin
            $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic report_test(input int num, input string name, input int unsigned start);
        $display("test %0d %s: %0d errors", num, name, err_cnt - start);
    endtask

    // --------------------------------------------------
    // comparing process, outputs are stable at the falling edge
    // --------------------------------------------------
    task automatic compare_entry(input string port, input resp_t exp,
                                 input mm_bus_pkg::word_t got);
        check_cnt++;
        if (cycle_cnt != exp.cycle + 1) begin
            $display("error at %0t: %s response for %h came %0d cycles after its request",
                     $time, port, exp.addr, cycle_cnt - exp.cycle);
            err_cnt++;
        end
        if (got !== exp.data) begin
            $display("error at %0t: %s addr %h got %h expected %h",
                     $time, port, exp.addr, got, exp.data);
            err_cnt++;
        end
    endtask

    always @(negedge clk_i) begin
        if (!rst_i) begin
            // data port
            if (data_rvalid_o) begin
                if (data_q.size() == 0) begin
                    $display("data port gave an rvalid at %0t with nothing outstanding", $time);
                    err_cnt++;
                end else begin
                    compare_entry("data", data_q.pop_front(), data_rdata_o);
                end
            end else if (data_q.size() != 0 && data_q[0].cycle + 1 <= cycle_cnt) begin
                $display("data port never answered the request to %h", data_q[0].addr);
                void'(data_q.pop_front());
                err_cnt++;
            end
            // instruction port
            if (instr_rvalid_o) begin
                if (instr_q.size() == 0) begin
                    $display("fetch port gave an rvalid at %0t with nothing outstanding", $time);
                    err_cnt++;
                end else begin
                    compare_entry("fetch", instr_q.pop_front(), instr_rdata_o);
                end
            end else if (instr_q.size() != 0 && instr_q[0].cycle + 1 <= cycle_cnt) begin
                $display("fetch port never answered the request to %h", instr_q[0].addr);
                void'(instr_q.pop_front());
                err_cnt++;
            end
            // stdout, one pulse per written character
            if (stdout_valid_o) begin
                if (char_q.size() == 0) begin
                    $display("stdout pulsed at %0t without a character written", $time);
                    err_cnt++;
                end else begin
                    compare_entry("stdout", char_q.pop_front(), {24'b0, stdout_char_o});
                end
            end else if (char_q.size() != 0 && char_q[0].cycle + 1 <= cycle_cnt) begin
                $display("stdout never showed the character %h", char_q[0].data[7:0]);
                void'(char_q.pop_front());
                err_cnt++;
            end
        end
    end

    // --------------------------------------------------
    // test sequence
    // --------------------------------------------------
    initial begin
        int unsigned       start;
        mm_bus_pkg::addr_t addr;
        mm_bus_pkg::word_t wdata;
        mm_bus_pkg::be_t   be;
        logic              touched [FILL_WORDS];
        string             text;

        seed         = 30;
        rst_i        = 1'b1;
        instr_req_i  = 1'b0;
        instr_addr_i = '0;
        data_req_i   = 1'b0;
        data_addr_i  = '0;
        data_we_i    = 1'b0;
        data_be_i    = '0;
        data_wdata_i = '0;
        exp_passed     = 1'b0;
        exp_failed     = 1'b0;
        exp_exit_valid = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk_i);
        rst_i = 1'b0;

        // 1: reset state, then one word through both ports
        start = err_cnt;
        check_out("instr_rvalid_o", instr_rvalid_o, 0);
        check_out("data_rvalid_o", data_rvalid_o, 0);
        check_out("stdout_valid_o", stdout_valid_o, 0);
        check_out("tests_passed_o", tests_passed_o, 0);
        check_out("tests_failed_o", tests_failed_o, 0);
        check_out("exit_valid_o", exit_valid_o, 0);
        check_out("exit_value_o", exit_value_o, 0);
        addr  = 32'h0000_0100;
        wdata = $random(seed);
        put_data(addr, 1'b1, 4'hF, wdata);
        next_cycle();
        put_data(addr, 1'b0, 4'h0, '0);
        put_fetch(addr);
        next_cycle();
        drain();
        report_test(1, "reset state and first access", start);

        // 2: fill a block, merge random byte writes, read back what was hit
        start = err_cnt;
        for (int i = 0; i < FILL_WORDS; i++) begin
            addr = i * 4;
            put_data(addr, 1'b1, 4'hF, fill_word(addr));
            next_cycle();
            touched[i] = 1'b0;
        end
        for (int i = 0; i < N_RAND; i++) begin
            // upper bits below the peripheral region alias onto the block
            addr  = $random(seed) & 32'h0FFF_F3FC;
            be    = $random(seed);
            wdata = $random(seed);
            put_data(addr, 1'b1, be, wdata);
            next_cycle();
            touched[addr[9:2]] = 1'b1;
        end
        for (int i = 0; i < FILL_WORDS; i++) begin
            if (touched[i]) begin
                put_data(i * 4, 1'b0, 4'h0, '0);
                next_cycle();
            end
        end
        drain();
        report_test(2, "byte enables", start);

        // 3: a data read every cycle, fetches on every other one
        start = err_cnt;
        for (int i = 0; i < N_PIPE; i++) begin
            put_data(i * 4, 1'b0, 4'h0, '0);
            if (i % 2 == 0) begin
                put_fetch((N_PIPE - 1 - i) * 4);
            end
            next_cycle();
        end
        drain();
        report_test(3, "pipelined reads", start);

        // 4: characters back to back, junk in the upper bytes
        start = err_cnt;
        text  = "hello, core\n";
        for (int i = 0; i < text.len(); i++) begin
            wdata      = $random(seed);
            wdata[7:0] = text[i];
            put_data(mm_vp_pkg::VP_STDOUT_ADDR, 1'b1, 4'hF, wdata);
            next_cycle();
        end
        drain();
        report_test(4, "stdout", start);

        // 5: status, exit and an unmapped read
        start = err_cnt;
        put_data(mm_vp_pkg::VP_STATUS_ADDR, 1'b1, 4'hF, 32'd42);
        next_cycle();
        drain();
        check_out("tests_passed_o", tests_passed_o, 0);
        check_out("tests_failed_o", tests_failed_o, 0);
        put_data(mm_vp_pkg::VP_STATUS_ADDR, 1'b1, 4'hF, mm_vp_pkg::TEST_PASS_MAGIC);
        next_cycle();
        put_data(mm_vp_pkg::VP_STATUS_ADDR, 1'b0, 4'h0, '0);
        next_cycle();
        wdata = $random(seed);
        put_data(mm_vp_pkg::VP_EXIT_ADDR, 1'b1, 4'hF, wdata);
        next_cycle();
        put_data(32'h3000_0000, 1'b0, 4'h0, '0);
        next_cycle();
        put_data(mm_vp_pkg::VP_STATUS_ADDR, 1'b0, 4'h0, '0);
        next_cycle();
        drain();
        check_out("tests_passed_o", tests_passed_o, 1);
        check_out("tests_failed_o", tests_failed_o, 0);
        check_out("exit_valid_o", exit_valid_o, 1);
        check_out("exit_value_o", exit_value_o, wdata);
        report_test(5, "status and exit", start);

        $display("tests: 5, checks: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/mm_ram.sv */
/*
 * memory-mapped RAM top level: data port decoder, dual-port RAM
 * and virtual peripheral registers
 */
`timescale 1ns/10ps
`default_nettype none

module mm_ram (
    input  wire                 clk_i,
    input  wire                 rst_i,
    // instruction port
    input  wire                 instr_req_i,
    input  mm_bus_pkg::addr_t   instr_addr_i,
    output logic                instr_gnt_o,
    output logic                instr_rvalid_o,
    output mm_bus_pkg::word_t   instr_rdata_o,
    // data port
    input  wire                 data_req_i,
    input  mm_bus_pkg::addr_t   data_addr_i,
    input  wire                 data_we_i,
    input  mm_bus_pkg::be_t     data_be_i,
    input  mm_bus_pkg::word_t   data_wdata_i,
    output logic                data_gnt_o,
    output logic                data_rvalid_o,
    output mm_bus_pkg::word_t   data_rdata_o,
    // virtual peripheral outputs
    output logic                stdout_valid_o,
    output logic [mm_bus_pkg::BYTE_WIDTH-1:0] stdout_char_o,
    output logic                tests_passed_o,
    output logic                tests_failed_o,
    output logic                exit_valid_o,
    output mm_bus_pkg::word_t   exit_value_o
);

    // decoder to targets
    logic                ram_req;
    logic                vp_req;
    mm_bus_pkg::addr_t   fwd_addr;
    logic                fwd_we;
    mm_bus_pkg::be_t     fwd_be;
    mm_bus_pkg::word_t   fwd_wdata;
    // targets back to decoder
    mm_bus_pkg::word_t   ram_rdata;
    mm_bus_pkg::word_t   vp_rdata;

    mm_req_decode decode_i (
        .clk_i(clk_i), .rst_i(rst_i),
        .data_req_i(data_req_i), .data_addr_i(data_addr_i), .data_we_i(data_we_i),
        .data_be_i(data_be_i), .data_wdata_i(data_wdata_i),
        .data_gnt_o(data_gnt_o), .data_rvalid_o(data_rvalid_o), .data_rdata_o(data_rdata_o),
        .ram_rdata_i(ram_rdata), .vp_rdata_i(vp_rdata),
        .ram_req_o(ram_req), .vp_req_o(vp_req), .fwd_addr_o(fwd_addr),
        .fwd_we_o(fwd_we), .fwd_be_o(fwd_be), .fwd_wdata_o(fwd_wdata)
    );

    mm_dp_ram dp_ram_i (
        .clk_i(clk_i), .rst_i(rst_i),
        .instr_req_i(instr_req_i), .instr_addr_i(instr_addr_i), .instr_gnt_o(instr_gnt_o),
        .instr_rvalid_o(instr_rvalid_o), .instr_rdata_o(instr_rdata_o),
        .ram_req_i(ram_req), .addr_i(fwd_addr), .we_i(fwd_we), .be_i(fwd_be),
        .wdata_i(fwd_wdata), .rdata_o(ram_rdata)
    );

    mm_vp_regs vp_regs_i (
        .clk_i(clk_i), .rst_i(rst_i),
        .vp_req_i(vp_req), .addr_i(fwd_addr), .we_i(fwd_we), .wdata_i(fwd_wdata),
        .rdata_o(vp_rdata),
        .stdout_valid_o(stdout_valid_o), .stdout_char_o(stdout_char_o),
        .tests_passed_o(tests_passed_o), .tests_failed_o(tests_failed_o),
        .exit_valid_o(exit_valid_o), .exit_value_o(exit_value_o)
    );

endmodule

`default_nettype wire

/* rtl/mm_vp_regs.sv */
/*
 * virtual peripherals: stdout character pulse, sticky pass/fail
 * status, exit value register and status word read-back
 */
`timescale 1ns/10ps
`default_nettype none

module mm_vp_regs (
    input  wire                 clk_i,
    input  wire                 rst_i,
    // request from the decoder
    input  wire                 vp_req_i,
    input  mm_bus_pkg::addr_t   addr_i,
    input  wire                 we_i,
    input  mm_bus_pkg::word_t   wdata_i,
    output mm_bus_pkg::word_t   rdata_o,
    // stdout
    output logic                stdout_valid_o,
    output logic [mm_bus_pkg::BYTE_WIDTH-1:0] stdout_char_o,
    // test status
    output logic                tests_passed_o,
    output logic                tests_failed_o,
    output logic                exit_valid_o,
    output mm_bus_pkg::word_t   exit_value_o
);

    mm_bus_pkg::addr_t          word_addr;
    logic                       wr_stdout;
    logic                       wr_status;
    logic                       wr_exit;
    logic                       rd_status;
    mm_vp_pkg::status_word_t    status_word;

    logic                       stdout_valid_q;
    logic [mm_bus_pkg::BYTE_WIDTH-1:0] stdout_char_q;
    logic                       passed_q;
    logic                       failed_q;
    logic                       exit_valid_q;
    mm_bus_pkg::word_t          exit_value_q;
    mm_bus_pkg::word_t          rdata_q;

    // --------------------------------------------------
    // address decode
    // --------------------------------------------------
    // byte offset ignored, registers are whole words
    assign word_addr = {addr_i[mm_bus_pkg::ADDR_WIDTH-1:mm_bus_pkg::WORD_OFFSET_WIDTH],
                        {mm_bus_pkg::WORD_OFFSET_WIDTH{1'b0}}};

    assign wr_stdout = vp_req_i && we_i && (word_addr == mm_vp_pkg::VP_STDOUT_ADDR);
    assign wr_status = vp_req_i && we_i && (word_addr == mm_vp_pkg::VP_STATUS_ADDR);
    assign wr_exit   = vp_req_i && we_i && (word_addr == mm_vp_pkg::VP_EXIT_ADDR);
    assign rd_status = vp_req_i && !we_i && (word_addr == mm_vp_pkg::VP_STATUS_ADDR);

    // --------------------------------------------------
    // write side
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            stdout_valid_q <= 1'b0;
            passed_q       <= 1'b0;
            failed_q       <= 1'b0;
            exit_valid_q   <= 1'b0;
            exit_value_q   <= '0;
        end else begin
            // one pulse per character
            stdout_valid_q <= wr_stdout;
            // first verdict sticks, the other one can no longer be set
            if (wr_status && wdata_i == mm_vp_pkg::TEST_PASS_MAGIC && !failed_q) begin
                passed_q <= 1'b1;
            end
            if (wr_status && wdata_i == mm_vp_pkg::TEST_FAIL_MAGIC && !passed_q) begin
                failed_q <= 1'b1;
            end
            if (wr_exit) begin
                exit_valid_q <= 1'b1;
                exit_value_q <= wdata_i;
            end
        end
    end

    // character byte, only meaningful with the valid pulse
    always_ff @(posedge clk_i) begin
        if (wr_stdout) begin
            stdout_char_q <= wdata_i[mm_bus_pkg::BYTE_WIDTH-1:0];
        end
    end

    // --------------------------------------------------
    // read side
    // --------------------------------------------------
    always_comb begin
        status_word = '0;
        status_word[mm_vp_pkg::STATUS_PASS_BIT] = passed_q;
        status_word[mm_vp_pkg::STATUS_FAIL_BIT] = failed_q;
        status_word[mm_vp_pkg::STATUS_EXIT_BIT] = exit_valid_q;
    end

    // only the status register reads back, the rest is zero
    always_ff @(posedge clk_i) begin
        rdata_q <= rd_status ? status_word : '0;
    end

    assign rdata_o        = rdata_q;
    assign stdout_valid_o = stdout_valid_q;
    assign stdout_char_o  = stdout_char_q;
    assign tests_passed_o = passed_q;
    assign tests_failed_o = failed_q;
    assign exit_valid_o   = exit_valid_q;
    assign exit_value_o   = exit_value_q;

    // pass and fail exclude each other
    assert property (@(posedge clk_i) disable iff (rst_i)
        !(tests_passed_o && tests_failed_o));

endmodule

`default_nettype wire

/* rtl/mm_dp_ram.sv */
/*
 * dual-port word RAM, read-only instruction port with its own
 * grant and rvalid, byte-enabled read/write data port
 */
`timescale 1ns/10ps
`default_nettype none

module mm_dp_ram (
    input  wire                 clk_i,
    input  wire                 rst_i,
    // instruction fetch port
    input  wire                 instr_req_i,
    input  mm_bus_pkg::addr_t   instr_addr_i,
    output logic                instr_gnt_o,
    output logic                instr_rvalid_o,
    output mm_bus_pkg::word_t   instr_rdata_o,
    // data port, already decoded as a RAM access
    input  wire                 ram_req_i,
    input  mm_bus_pkg::addr_t   addr_i,
    input  wire                 we_i,
    input  mm_bus_pkg::be_t     be_i,
    input  mm_bus_pkg::word_t   wdata_i,
    output mm_bus_pkg::word_t   rdata_o
);

    // storage, left uninitialised
    mm_bus_pkg::word_t    mem [mm_bus_pkg::RAM_WORDS];

    // word indices, upper address bits wrap around
    mm_bus_pkg::ram_index_t instr_idx;
    mm_bus_pkg::ram_index_t data_idx;

    logic                 instr_rvalid_q;
    mm_bus_pkg::word_t    instr_rdata_q;
    mm_bus_pkg::word_t    data_rdata_q;

    assign instr_idx =
        instr_addr_i[mm_bus_pkg::RAM_ADDR_WIDTH-1:mm_bus_pkg::WORD_OFFSET_WIDTH];
    assign data_idx =
        addr_i[mm_bus_pkg::RAM_ADDR_WIDTH-1:mm_bus_pkg::WORD_OFFSET_WIDTH];

    // --------------------------------------------------
    // instruction port
    // --------------------------------------------------
    // always ready
    assign instr_gnt_o = instr_req_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            instr_rvalid_q <= 1'b0;
        end else begin
            instr_rvalid_q <= instr_req_i;
        end
    end

    // fetch word, held until the next fetch
    always_ff @(posedge clk_i) begin
        if (instr_req_i) begin
            instr_rdata_q <= mem[instr_idx];
        end
    end

    assign instr_rvalid_o = instr_rvalid_q;
    assign instr_rdata_o  = instr_rdata_q;

    // --------------------------------------------------
    // data port
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (ram_req_i) begin
            if (we_i) begin
                // merge only the enabled byte lanes
                for (int b = 0; b < mm_bus_pkg::BE_WIDTH; b++) begin
                    if (be_i[b]) begin
                        mem[data_idx][b*mm_bus_pkg::BYTE_WIDTH +: mm_bus_pkg::BYTE_WIDTH] <=
                            wdata_i[b*mm_bus_pkg::BYTE_WIDTH +: mm_bus_pkg::BYTE_WIDTH];
                    end
                end
            end else begin
                data_rdata_q <= mem[data_idx];
            end
        end
    end

    // the decoder decides whether this word is returned
    assign rdata_o = data_rdata_q;

    // fetches are whole words
    assert property (@(posedge clk_i) disable iff (rst_i)
        instr_req_i |-> (instr_addr_i[mm_bus_pkg::WORD_OFFSET_WIDTH-1:0] == '0));

endmodule

`default_nettype wire

/* rtl/mm_req_decode.sv */
/*
 * data port request decoder: grant, target selection toward RAM or
 * peripherals, and the one-cycle response path back to the master
 */
`timescale 1ns/10ps
`default_nettype none

module mm_req_decode (
    input  wire                 clk_i,
    input  wire                 rst_i,
    // data port from the master
    input  wire                 data_req_i,
    input  mm_bus_pkg::addr_t   data_addr_i,
    input  wire                 data_we_i,
    input  mm_bus_pkg::be_t     data_be_i,
    input  mm_bus_pkg::word_t   data_wdata_i,
    output logic                data_gnt_o,
    output logic                data_rvalid_o,
    output mm_bus_pkg::word_t   data_rdata_o,
    // read data coming back from the two targets
    input  mm_bus_pkg::word_t   ram_rdata_i,
    input  mm_bus_pkg::word_t   vp_rdata_i,
    // forwarded request
    output logic                ram_req_o,
    output logic                vp_req_o,
    output mm_bus_pkg::addr_t   fwd_addr_o,
    output logic                fwd_we_o,
    output mm_bus_pkg::be_t     fwd_be_o,
    output mm_bus_pkg::word_t   fwd_wdata_o
);

    // word-aligned copy of the request address
    mm_bus_pkg::addr_t   word_addr;
    // target of the request in this cycle
    mm_vp_pkg::target_e  req_target;
    // response bookkeeping for the next cycle
    logic                pending_q;
    mm_vp_pkg::target_e  resp_target_q;

    // --------------------------------------------------
    // request side
    // --------------------------------------------------
    // no back-pressure, every request is granted at once
    assign data_gnt_o = data_req_i;

    assign word_addr = {data_addr_i[mm_bus_pkg::ADDR_WIDTH-1:mm_bus_pkg::WORD_OFFSET_WIDTH],
                        {mm_bus_pkg::WORD_OFFSET_WIDTH{1'b0}}};

    always_comb begin
        req_target = mm_vp_pkg::TGT_NONE;
        if (data_addr_i < mm_vp_pkg::VP_REGION_BASE) begin
            // RAM window, upper bits are dropped by the RAM itself
            req_target = mm_vp_pkg::TGT_RAM;
        end else if (word_addr == mm_vp_pkg::VP_STDOUT_ADDR ||
                     word_addr == mm_vp_pkg::VP_STATUS_ADDR ||
                     word_addr == mm_vp_pkg::VP_EXIT_ADDR) begin
            req_target = mm_vp_pkg::TGT_VP;
        end
    end

    // at most one forward request, none for unmapped space
    assign ram_req_o = data_req_i && (req_target == mm_vp_pkg::TGT_RAM);
    assign vp_req_o  = data_req_i && (req_target == mm_vp_pkg::TGT_VP);

    // shared request fields, qualified by the two req lines
    assign fwd_addr_o  = data_addr_i;
    assign fwd_we_o    = data_we_i;
    assign fwd_be_o    = data_be_i;
    assign fwd_wdata_o = data_wdata_i;

    // --------------------------------------------------
    // response side
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pending_q     <= 1'b0;
            resp_target_q <= mm_vp_pkg::TGT_NONE;
        end else begin
            pending_q <= data_req_i;
            // a write answers with zero, so it is recorded as NONE
            resp_target_q <= data_we_i ? mm_vp_pkg::TGT_NONE : req_target;
        end
    end

    assign data_rvalid_o = pending_q;

    // read data of whichever target the response belongs to
    always_comb begin
        case (resp_target_q)
            mm_vp_pkg::TGT_RAM: data_rdata_o = ram_rdata_i;
            mm_vp_pkg::TGT_VP:  data_rdata_o = vp_rdata_i;
            default:            data_rdata_o = '0;
        endcase
    end

    // one target per request
    assert property (@(posedge clk_i) disable iff (rst_i)
        !(ram_req_o && vp_req_o));

    // each granted request gets its rvalid on the next cycle, and only then
    assert property (@(posedge clk_i) disable iff (rst_i)
        (data_req_i && data_gnt_o) |=> data_rvalid_o);
    assert property (@(posedge clk_i) disable iff (rst_i)
        !data_req_i |=> !data_rvalid_o);

endmodule

`default_nettype wire

/* rtl/mm_vp_pkg.sv */
/*
 * virtual peripheral address map, test-status magic values,
 * decoder target enum and the layout of the status word
 */
`default_nettype none

package mm_vp_pkg;

    // --------------------------------------------------
    // address map
    // --------------------------------------------------
    // everything below this goes to the RAM, wrapping on its size
    localparam mm_bus_pkg::addr_t VP_REGION_BASE = 32'h1000_0000;
    // low byte of a write is printed
    localparam mm_bus_pkg::addr_t VP_STDOUT_ADDR = 32'h1000_0000;
    // pass / fail verdict, read back as status_word_t
    localparam mm_bus_pkg::addr_t VP_STATUS_ADDR = 32'h2000_0000;
    // exit value of the program
    localparam mm_bus_pkg::addr_t VP_EXIT_ADDR = 32'h2000_0004;

    // values written to the status register
    localparam mm_bus_pkg::word_t TEST_PASS_MAGIC = 32'd123456789;
    localparam mm_bus_pkg::word_t TEST_FAIL_MAGIC = 32'd1;

    // bit positions in the status word
    localparam int unsigned STATUS_PASS_BIT = 0;
    localparam int unsigned STATUS_FAIL_BIT = 1;
    localparam int unsigned STATUS_EXIT_BIT = 2;

    // where a data request, and later its response, belongs
    typedef enum logic [1:0] {TGT_NONE, TGT_RAM, TGT_VP} target_e;

    typedef logic [31:0] status_word_t;

endpackage

`default_nettype wire

/* rtl/mm_bus_pkg.sv */
/*
 * bus widths of the request/grant/rvalid ports, RAM geometry,
 * and plain-vector types for addresses, data words and byte enables
 */
`default_nettype none

package mm_bus_pkg;

    // --------------------------------------------------
    // port widths
    // --------------------------------------------------
    localparam int unsigned ADDR_WIDTH = 32;
    localparam int unsigned DATA_WIDTH = 32;
    localparam int unsigned BYTE_WIDTH = 8;
    // one enable bit per byte lane
    localparam int unsigned BE_WIDTH = DATA_WIDTH / BYTE_WIDTH;
    // byte offset bits inside a word
    localparam int unsigned WORD_OFFSET_WIDTH = $clog2(BE_WIDTH);

    // --------------------------------------------------
    // RAM geometry
    // --------------------------------------------------
    // byte address bits covered by the RAM, 4 KiB
    localparam int unsigned RAM_ADDR_WIDTH = 12;
    localparam int unsigned RAM_INDEX_WIDTH = RAM_ADDR_WIDTH - WORD_OFFSET_WIDTH;
    localparam int unsigned RAM_WORDS = 2 ** RAM_INDEX_WIDTH;

    // byte address on either port
    typedef logic [ADDR_WIDTH-1:0] addr_t;
    // data word, read or written
    typedef logic [DATA_WIDTH-1:0] word_t;
    // byte lane enables of a data write
    typedef logic [BE_WIDTH-1:0] be_t;
    // word index into the RAM array
    typedef logic [RAM_INDEX_WIDTH-1:0] ram_index_t;

endpackage

`default_nettype wire
